//--- verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Word storage of the test RAM.
    localparam int DATA_MEM_WORDS = 256;
    localparam int DATA_MEM_ADDR_BITS = 8;  // Word index is addr[9:2].

    // Access size codes on the size signals.
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;  // Code 3 behaves as a word access.

    // Cycles from acceptance to data_ok.
    localparam int RAM_DELAY = 2;

    // Outstanding request tracking in the arbiter.
    // The depth must stay above the largest RAM delay in use,
    // otherwise the arbiter stalls before the pipeline is full.
    localparam int ORDER_DEPTH = 4;
    localparam int ORDER_PTR_BITS = 2;

    // Owner codes held in the order FIFO.
    localparam logic OWNER_INST = 1'b0;
    localparam logic OWNER_DATA = 1'b1;

endpackage

`default_nettype wire

//--- verilog/test_ram.sv
`default_nettype none

module test_ram
    import mem_pkg::*;
#(
    parameter int delay = RAM_DELAY
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic        wr,
    input  logic [1:0]  size,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        addr_ok,
    output logic        data_ok
);

    logic [31:0] mem [DATA_MEM_WORDS];

    logic [DATA_MEM_ADDR_BITS-1:0] word_idx;
    logic [3:0]                    lane_mask;
    logic [31:0]                   old_word;
    logic [31:0]                   merged_word;
    logic [31:0]                   read_word;

    logic [delay-1:0][31:0] rdata_pipe;
    logic [delay-1:0]       valid_pipe;

    assign addr_ok = req;  // Every request is taken at once.

    assign word_idx = addr[DATA_MEM_ADDR_BITS+1:2];  // Upper bits alias.
    assign old_word = mem[word_idx];

    always_comb begin
        case (size)
            SIZE_BYTE: lane_mask = 4'b0001 << addr[1:0];
            SIZE_HALF: lane_mask = 4'b0011 << {addr[1], 1'b0};
            default:   lane_mask = 4'b1111;
        endcase
    end

    always_comb begin
        merged_word = old_word;
        for (int i = 0; i < 4; i++) begin
            if (lane_mask[i]) begin
                merged_word[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
    end

    // Writes answer with zero data.
    assign read_word = wr ? 32'd0 : old_word;

    always_ff @(posedge clk) begin
        if (req && wr) begin
            mem[word_idx] <= merged_word;
        end
    end

    always_ff @(posedge clk) begin
        rdata_pipe[0] <= read_word;
        for (int i = 1; i < delay; i++) begin
            rdata_pipe[i] <= rdata_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= req;
            for (int i = 1; i < delay; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    assign rdata   = rdata_pipe[delay-1];
    assign data_ok = valid_pipe[delay-1];

endmodule

`default_nettype wire

//--- verilog/order_fifo.sv
`default_nettype none

module order_fifo
    import mem_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic push_owner,
    input  logic pop,
    output logic head_owner,
    output logic full
);

    logic owners [ORDER_DEPTH];

    logic [ORDER_PTR_BITS-1:0] wr_ptr;
    logic [ORDER_PTR_BITS-1:0] rd_ptr;
    logic [ORDER_PTR_BITS:0]   count;
    logic                      push_en;
    logic                      pop_en;

    assign full       = (count == (ORDER_PTR_BITS + 1)'(ORDER_DEPTH));
    assign head_owner = owners[rd_ptr];

    assign push_en = push && !full;
    assign pop_en  = pop && (count != '0);  // A stray pop on empty is ignored.

    always_ff @(posedge clk) begin
        if (push_en) begin
            owners[wr_ptr] <= push_owner;
        end
    end

    // Pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_en, pop_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/sram_arbiter.sv
`default_nettype none

module sram_arbiter
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        inst_req,
    input  logic [31:0] inst_addr,
    output logic [31:0] inst_rdata,
    output logic        inst_addr_ok,
    output logic        inst_data_ok,

    input  logic        data_req,
    input  logic        data_wr,
    input  logic [1:0]  data_size,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    output logic [31:0] data_rdata,
    output logic        data_addr_ok,
    output logic        data_data_ok,

    output logic        ram_req,
    output logic        ram_wr,
    output logic [1:0]  ram_size,
    output logic [31:0] ram_addr,
    output logic [31:0] ram_wdata,
    input  logic [31:0] ram_rdata,
    input  logic        ram_addr_ok,
    input  logic        ram_data_ok
);

    logic fifo_full;
    logic head_owner;
    logic accept;
    logic grant_owner;
    logic to_inst;
    logic to_data;

    assign grant_owner = data_req ? OWNER_DATA : OWNER_INST;  // Data port has priority.

    // Nothing goes out while the order FIFO cannot record the owner.
    assign ram_req   = (data_req || inst_req) && !fifo_full;
    assign ram_wr    = data_req ? data_wr    : 1'b0;
    assign ram_size  = data_req ? data_size  : SIZE_WORD;
    assign ram_addr  = data_req ? data_addr  : inst_addr;
    assign ram_wdata = data_req ? data_wdata : 32'd0;

    assign accept = ram_req && ram_addr_ok;

    assign data_addr_ok = accept && (grant_owner == OWNER_DATA);
    assign inst_addr_ok = accept && (grant_owner == OWNER_INST);

    order_fifo order_fifo_i (
        .clk        (clk),
        .rst        (rst),
        .push       (accept),
        .push_owner (grant_owner),
        .pop        (ram_data_ok),
        .head_owner (head_owner),
        .full       (fifo_full)
    );

    // The oldest outstanding request owns the returning response.
    assign to_inst = ram_data_ok && (head_owner == OWNER_INST);
    assign to_data = ram_data_ok && (head_owner == OWNER_DATA);

    assign inst_data_ok = to_inst;
    assign data_data_ok = to_data;
    assign inst_rdata   = to_inst ? ram_rdata : 32'd0;
    assign data_rdata   = to_data ? ram_rdata : 32'd0;

endmodule

`default_nettype wire

//--- verilog/mem_subsystem.sv
`default_nettype none

module mem_subsystem
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        inst_req,
    input  logic [31:0] inst_addr,
    output logic [31:0] inst_rdata,
    output logic        inst_addr_ok,
    output logic        inst_data_ok,

    input  logic        data_req,
    input  logic        data_wr,
    input  logic [1:0]  data_size,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    output logic [31:0] data_rdata,
    output logic        data_addr_ok,
    output logic        data_data_ok
);

    logic        ram_req;
    logic        ram_wr;
    logic [1:0]  ram_size;
    logic [31:0] ram_addr;
    logic [31:0] ram_wdata;
    logic [31:0] ram_rdata;
    logic        ram_addr_ok;
    logic        ram_data_ok;

    sram_arbiter sram_arbiter_i (
        .clk          (clk),
        .rst          (rst),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_rdata   (inst_rdata),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_size    (data_size),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .ram_req      (ram_req),
        .ram_wr       (ram_wr),
        .ram_size     (ram_size),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .ram_rdata    (ram_rdata),
        .ram_addr_ok  (ram_addr_ok),
        .ram_data_ok  (ram_data_ok)
    );

    test_ram #(
        .delay (RAM_DELAY)
    ) test_ram_i (
        .clk     (clk),
        .rst     (rst),
        .req     (ram_req),
        .wr      (ram_wr),
        .size    (ram_size),
        .addr    (ram_addr),
        .wdata   (ram_wdata),
        .rdata   (ram_rdata),
        .addr_ok (ram_addr_ok),
        .data_ok (ram_data_ok)
    );

endmodule

`default_nettype wire

//--- testbench/tb_mem_subsystem.sv
`default_nettype none

module tb_mem_subsystem
    import mem_pkg::*;
();

    logic        clk = 1'b0;
    logic        rst;
    logic        inst_req;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic        inst_addr_ok;
    logic        inst_data_ok;
    logic        data_req;
    logic        data_wr;
    logic [1:0]  data_size;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [31:0] data_rdata;
    logic        data_addr_ok;
    logic        data_data_ok;

    integer seed = 20;
    int     wait_limit = 100;
    int     cycle_cnt = 0;

    logic [31:0] model [DATA_MEM_WORDS];  // Reference copy of the RAM contents.
    logic [31:0] data_exp_q[$];
    logic [31:0] inst_exp_q[$];
    int          data_time_q[$];
    int          inst_time_q[$];

    mem_subsystem mem_subsystem_i (
        .clk          (clk),
        .rst          (rst),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_rdata   (inst_rdata),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_size    (data_size),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok)
    );

    always #5 clk = ~clk;

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped after an error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "Simulation stopped after a mismatch.");
        end
    endtask

    // Lane selection follows the size code and the low address bits.
    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [1:0] size,
                                                input logic [1:0] offset);
        logic [31:0] result;
        logic        take;
        result = old_word;
        for (int lane = 0; lane < 4; lane++) begin
            if (size == SIZE_BYTE) begin
                take = (lane == int'(offset));
            end else if (size == SIZE_HALF) begin
                take = ((lane / 2) == int'(offset[1]));
            end else begin
                take = 1'b1;
            end
            if (take) begin
                result[lane*8 +: 8] = new_word[lane*8 +: 8];
            end
        end
        return result;
    endfunction

    // Responses are checked before new acceptances are recorded.
    always @(negedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (!rst) begin
            if (data_data_ok) begin
                if (data_exp_q.size() == 0) begin
                    stop_run("The data port got a response with no request outstanding.");
                end else begin
                    check_value("data_rdata", data_rdata, data_exp_q.pop_front());
                    check_value("data latency", cycle_cnt - data_time_q.pop_front(), RAM_DELAY);
                end
            end
            if (inst_data_ok) begin
                if (inst_exp_q.size() == 0) begin
                    stop_run("The instruction port got a response with no request outstanding.");
                end else begin
                    check_value("inst_rdata", inst_rdata, inst_exp_q.pop_front());
                    check_value("inst latency", cycle_cnt - inst_time_q.pop_front(), RAM_DELAY);
                end
            end
            if (data_req && inst_req) begin
                check_value("inst_addr_ok", 32'(inst_addr_ok), 32'd0);
                check_value("data_addr_ok", 32'(data_addr_ok), 32'd1);
            end
            if (data_req && data_addr_ok) begin
                if (data_wr) begin
                    data_exp_q.push_back(32'd0);
                    model[data_addr[DATA_MEM_ADDR_BITS+1:2]] =
                        merge_lanes(model[data_addr[DATA_MEM_ADDR_BITS+1:2]], data_wdata,
                                    data_size, data_addr[1:0]);
                end else begin
                    data_exp_q.push_back(model[data_addr[DATA_MEM_ADDR_BITS+1:2]]);
                end
                data_time_q.push_back(cycle_cnt);
            end
            if (inst_req && inst_addr_ok) begin
                inst_exp_q.push_back(model[inst_addr[DATA_MEM_ADDR_BITS+1:2]]);
                inst_time_q.push_back(cycle_cnt);
            end
        end
    end

    // Leaves data_req high so the next call follows on the next cycle.
    task automatic data_access(input logic wr, input logic [1:0] size,
                               input logic [31:0] addr, input logic [31:0] wdata);
        logic accepted;
        int   waited;
        data_req   = 1'b1;
        data_wr    = wr;
        data_size  = size;
        data_addr  = addr;
        data_wdata = wdata;
        accepted   = 1'b0;
        waited     = 0;
        while (!accepted) begin
            @(negedge clk);
            accepted = data_addr_ok;
            waited++;
            if (!accepted && waited > wait_limit) begin
                stop_run("A data port request was never accepted.");
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_drain();
        int waited;
        data_req = 1'b0;
        inst_req = 1'b0;
        waited   = 0;
        while (data_exp_q.size() != 0 || inst_exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > wait_limit) begin
                stop_run("Outstanding requests were not answered in time.");
            end
        end
    endtask

    initial begin
        logic [31:0] addr;
        logic        inst_pending;
        logic        data_pending;
        logic        inst_acc;
        logic        data_acc;
        int          inst_wait;
        int          data_wait;
        int          i;

        rst        = 1'b1;
        inst_req   = 1'b0;
        inst_addr  = 32'd0;
        data_req   = 1'b1;  // A read held through reset must not be answered afterwards.
        data_wr    = 1'b0;
        data_size  = SIZE_WORD;
        data_addr  = 32'd0;
        data_wdata = 32'd0;
        repeat (8) @(posedge clk);
        #1;
        rst      = 1'b0;
        data_req = 1'b0;

        // Idle outputs after reset.
        repeat (10) begin
            @(negedge clk);
            check_value("inst_data_ok", 32'(inst_data_ok), 32'd0);
            check_value("data_data_ok", 32'(data_data_ok), 32'd0);
        end
        @(posedge clk);
        #1;

        for (i = 0; i < DATA_MEM_WORDS; i++) begin
            data_access(1'b1, SIZE_WORD, i << 2, $random(seed));
        end
        for (i = 0; i < DATA_MEM_WORDS; i++) begin
            data_access(1'b0, SIZE_WORD, i << 2, 32'd0);
        end
        wait_drain();

        // Partial writes, each read back on its own.
        for (i = 0; i < 60; i++) begin
            addr = $random(seed);
            data_access(1'b1, {1'b0, 1'($random(seed))}, addr, $random(seed));
            data_access(1'b0, SIZE_WORD, addr, 32'd0);
            wait_drain();
        end

        for (i = 0; i < 80; i++) begin
            addr = $random(seed);
            data_access(1'b1, 2'($random(seed)), addr, $random(seed));
            data_access(1'b0, SIZE_WORD, addr, 32'd0);  // Same word right after the write.
        end
        wait_drain();

        inst_pending = 1'b0;
        data_pending = 1'b0;
        inst_wait    = 0;
        data_wait    = 0;
        i            = 0;
        while (i < 400 || inst_pending || data_pending) begin
            if (i < 400 && !inst_pending && ($random(seed) & 1)) begin
                inst_req     = 1'b1;
                inst_addr    = $random(seed);
                inst_pending = 1'b1;
                inst_wait    = 0;
            end
            if (i < 400 && !data_pending && ($random(seed) & 1)) begin
                data_req     = 1'b1;
                data_wr      = 1'($random(seed));
                data_size    = 2'($random(seed));
                data_addr    = $random(seed);
                data_wdata   = $random(seed);
                data_pending = 1'b1;
                data_wait    = 0;
            end
            @(negedge clk);
            inst_acc = inst_addr_ok;
            data_acc = data_addr_ok;
            @(posedge clk);
            #1;
            if (inst_acc) begin
                inst_pending = 1'b0;
                inst_req     = 1'b0;
            end else if (inst_pending) begin
                inst_wait++;
                if (inst_wait > wait_limit) begin
                    stop_run("An instruction request waited too long for acceptance.");
                end
            end
            if (data_acc) begin
                data_pending = 1'b0;
                data_req     = 1'b0;
            end else if (data_pending) begin
                data_wait++;
                if (data_wait > wait_limit) begin
                    stop_run("A data request waited too long for acceptance.");
                end
            end
            i++;
        end
        wait_drain();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/mem_pkg.sv
verilog/test_ram.sv
verilog/order_fifo.sv
verilog/sram_arbiter.sv
verilog/mem_subsystem.sv
testbench/tb_mem_subsystem.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - files:
      - verilog/mem_pkg.sv
      - verilog/test_ram.sv
      - verilog/order_fifo.sv
      - verilog/sram_arbiter.sv
      - verilog/mem_subsystem.sv
  - target: test
    files:
      - testbench/tb_mem_subsystem.sv
